/* design/stm_event_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
// ##########################################################
// fifo_depth must be a power of two and at least 2.
// first word fall through, and a push is visible one clock later.
// ##########################################################

module stm_event_fifo #(
  parameter int fifo_depth = 8
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        evt_strobe,
  input  logic [15:0] evt_id,
  input  logic [31:0] evt_value,
  input  logic [31:0] evt_ts,
  input  logic        pop,
  input  logic        lost_clear,
  output logic        ev_avail,
  output logic [15:0] ev_id,
  output logic [31:0] ev_value,
  output logic [31:0] ev_ts,
  output logic [15:0] lost_count
);

  localparam int addr_w = $clog2(fifo_depth);
  localparam logic [addr_w:0] full_level = fifo_depth[addr_w:0];

  logic [15:0]       id_mem  [fifo_depth];
  logic [31:0]       val_mem [fifo_depth];
  logic [31:0]       ts_mem  [fifo_depth];
  logic [addr_w-1:0] wr_ptr;
  logic [addr_w-1:0] rd_ptr;
  logic [addr_w:0]   count;  // one bit wider than the pointers so full is distinct from empty.
  logic              full;
  logic              push;
  logic              do_pop;
  logic              drop;

  assign full     = (count == full_level);
  assign push     = evt_strobe && !full;
  assign drop     = evt_strobe && full;  // a pop in the same cycle does not rescue it.
  assign do_pop   = pop && ev_avail;
  assign ev_avail = (count != '0);

  // head of the queue, read straight out of the arrays.
  assign ev_id    = id_mem[rd_ptr];
  assign ev_value = val_mem[rd_ptr];
  assign ev_ts    = ts_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      id_mem[wr_ptr]  <= evt_id;
      val_mem[wr_ptr] <= evt_value;
      ts_mem[wr_ptr]  <= evt_ts;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap at the power of two.
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // both or neither leave the level alone.
      endcase
    end
  end

  // lost counter saturates, and a drop in the clear cycle still counts.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lost_count <= '0;
    end else if (lost_clear) begin
      lost_count <= drop ? 16'd1 : 16'd0;
    end else if (drop && (lost_count != 16'hffff)) begin
      lost_count <= lost_count + 16'd1;
    end
  end

  a_no_overfill: assert property (@(posedge clk) disable iff (!arst_n)
    count <= full_level);

  // the packetizer only pops an entry it has seen.
  a_no_empty_pop: assert property (@(posedge clk) disable iff (!arst_n)
    pop |-> ev_avail);

endmodule

`default_nettype wire

/* design/stm_packetizer.sv */
`timescale 1ns/1ps
`default_nettype none
// ##########################################################
// the FSM idles one cycle between packets, and overflow wins over events.
// id is expected to stay constant while a packet is in flight.
// ##########################################################

module stm_packetizer #(
  parameter logic [15:0] host_addr = 16'h0000
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [15:0]                   id,
  input  logic                          ev_avail,
  input  logic [15:0]                   ev_id,
  input  logic [31:0]                   ev_value,
  input  logic [31:0]                   ev_ts,
  input  logic [15:0]                   lost_count,
  input  logic                          debug_out_ready,
  output logic                          pop,
  output logic                          lost_clear,
  output logic                          debug_out_valid,
  output logic [stm_pkg::flit_width-1:0] debug_out_data,
  output logic                          debug_out_last
);
  import stm_pkg::*;

  pkt_state_e  state;
  pkt_state_e  next_state;
  stm_type_e   hold_type;   // selects the flit sequence after the type word.
  logic [31:0] hold_ts;
  logic [15:0] hold_id;
  logic [31:0] hold_value;
  logic [15:0] hold_lost;
  logic        accept;

  // loads happen only from idle, and the lost count is checked first.
  assign lost_clear = (state == pkt_idle) && (lost_count != 16'h0000);
  assign pop        = (state == pkt_idle) && (lost_count == 16'h0000) && ev_avail;

  assign debug_out_valid = (state != pkt_idle);
  assign debug_out_last  = (state == pkt_val_hi) || (state == pkt_lost);
  assign accept          = debug_out_valid && debug_out_ready;

  always_comb begin
    next_state = state;
    case (state)
      pkt_idle:   if (lost_clear || pop) next_state = pkt_dest;
      pkt_dest:   if (accept) next_state = pkt_src;
      pkt_src:    if (accept) next_state = pkt_type;
      pkt_type:   if (accept) next_state = (hold_type == evt_overflow) ? pkt_lost : pkt_ts_lo;
      pkt_ts_lo:  if (accept) next_state = pkt_ts_hi;
      pkt_ts_hi:  if (accept) next_state = pkt_id;
      pkt_id:     if (accept) next_state = pkt_val_lo;
      pkt_val_lo: if (accept) next_state = pkt_val_hi;
      pkt_val_hi: if (accept) next_state = pkt_idle;
      pkt_lost:   if (accept) next_state = pkt_idle;
      default:    next_state = pkt_idle;
    endcase
  end

  // flit data depends only on the state and the holding registers, so it holds under stall.
  always_comb begin
    case (state)
      pkt_dest:   debug_out_data = host_addr;
      pkt_src:    debug_out_data = id;
      pkt_type:   debug_out_data = hold_type;
      pkt_ts_lo:  debug_out_data = hold_ts[flit_width-1:0];
      pkt_ts_hi:  debug_out_data = hold_ts[2*flit_width-1:flit_width];
      pkt_id:     debug_out_data = hold_id;
      pkt_val_lo: debug_out_data = hold_value[flit_width-1:0];
      pkt_val_hi: debug_out_data = hold_value[2*flit_width-1:flit_width];
      pkt_lost:   debug_out_data = hold_lost;
      default:    debug_out_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) state <= pkt_idle;
    else state <= next_state;
  end

  always_ff @(posedge clk) begin
    if (lost_clear) begin
      hold_type <= evt_overflow;
      hold_lost <= lost_count;  // the FIFO clears its counter on this same edge.
    end else if (pop) begin
      hold_type  <= evt_trace;
      hold_ts    <= ev_ts;
      hold_id    <= ev_id;
      hold_value <= ev_value;
    end
  end

  a_hold_stall: assert property (@(posedge clk) disable iff (!arst_n)
    (debug_out_valid && !debug_out_ready) |=>
      ($stable(debug_out_data) && $stable(debug_out_last)));

endmodule

`default_nettype wire

/* design/stm_pkg.sv */
`default_nettype none
// ##########################################################
// constants and enums shared by the trace stages and the testbench.
// flit width is fixed at 16 and each packet word is one flit.
// ##########################################################

package stm_pkg;

  // width of one debug flit on the host link.
  localparam int flit_width = 16;

  // upper instruction half that marks a software trace point.
  localparam logic [15:0] marker_opcode = 16'h1500;

  // register whose last writeback travels with each event.
  localparam logic [4:0] trace_reg = 5'd3;

  // packet type word, sent as the third flit of every packet.
  typedef enum logic [15:0] {
    evt_trace    = 16'd1,  // one captured marker.
    evt_overflow = 16'd2   // count of events dropped on a full FIFO.
  } stm_type_e;

  // packetizer FSM, one state per flit plus idle.
  typedef enum logic [3:0] {
    pkt_idle,
    pkt_dest,
    pkt_src,
    pkt_type,
    pkt_ts_lo,
    pkt_ts_hi,
    pkt_id,
    pkt_val_lo,
    pkt_val_hi,
    pkt_lost    // overflow packets end here instead of ts_lo.
  } pkt_state_e;

endpackage

`default_nettype wire

/* design/stm_top.sv */
`timescale 1ns/1ps
`default_nettype none
// ##########################################################
// marker to first flit takes at least three clocks.
// up to fifo_depth + 1 events pending, later ones count as lost.
// ##########################################################

module stm_top #(
  parameter int          fifo_depth = 8,
  parameter logic [15:0] host_addr  = 16'h0000
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [15:0]                   id,
  input  logic                          trace_valid,
  input  logic [31:0]                   trace_insn,
  input  logic                          trace_wben,
  input  logic [4:0]                    trace_wbreg,
  input  logic [31:0]                   trace_wbdata,
  output logic                          debug_out_valid,
  output logic [stm_pkg::flit_width-1:0] debug_out_data,
  output logic                          debug_out_last,
  input  logic                          debug_out_ready
);

  logic        evt_strobe;  // capture to FIFO.
  logic [15:0] evt_id;
  logic [31:0] evt_value;
  logic [31:0] evt_ts;
  logic        ev_avail;    // FIFO to packetizer.
  logic [15:0] ev_id;
  logic [31:0] ev_value;
  logic [31:0] ev_ts;
  logic [15:0] lost_count;
  logic        pop;         // packetizer back to FIFO.
  logic        lost_clear;

  stm_trace_capture u_capture (
    .clk, .arst_n, .trace_valid, .trace_insn, .trace_wben, .trace_wbreg, .trace_wbdata,
    .evt_strobe, .evt_id, .evt_value, .evt_ts
  );

  stm_event_fifo #(
    .fifo_depth(fifo_depth)
  ) u_fifo (
    .clk, .arst_n, .evt_strobe, .evt_id, .evt_value, .evt_ts, .pop, .lost_clear,
    .ev_avail, .ev_id, .ev_value, .ev_ts, .lost_count
  );

  stm_packetizer #(
    .host_addr(host_addr)
  ) u_packetizer (
    .clk, .arst_n, .id, .ev_avail, .ev_id, .ev_value, .ev_ts, .lost_count,
    .debug_out_ready, .pop, .lost_clear, .debug_out_valid, .debug_out_data, .debug_out_last
  );

endmodule

`default_nettype wire

/* design/stm_trace_capture.sv */
`timescale 1ns/1ps
`default_nettype none
// ##########################################################
// outputs are registered, so evt_strobe trails the marker by one clock.
// the shadow follows every writeback, whether or not trace_valid is high.
// ##########################################################

module stm_trace_capture (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        trace_valid,
  input  logic [31:0] trace_insn,
  input  logic        trace_wben,
  input  logic [4:0]  trace_wbreg,
  input  logic [31:0] trace_wbdata,
  output logic        evt_strobe,
  output logic [15:0] evt_id,
  output logic [31:0] evt_value,
  output logic [31:0] evt_ts
);
  import stm_pkg::*;

  logic [31:0] reg_shadow;  // last value written to the traced register.
  logic [31:0] ts_count;    // free running timestamp, zero in the first cycle out of reset.
  logic        is_marker;
  logic        wb_hit;

  // a marker needs a retired insn, the marker opcode and a nonzero id.
  assign is_marker = trace_valid && (trace_insn[31:16] == marker_opcode) &&
                     (trace_insn[15:0] != 16'h0000);
  assign wb_hit    = trace_wben && (trace_wbreg == trace_reg);  // writeback to r3.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ts_count   <= '0;
      reg_shadow <= '0;
      evt_strobe <= 1'b0;
    end else begin
      ts_count   <= ts_count + 32'd1;  // wraps after 2^32 cycles.
      evt_strobe <= is_marker;         // one pulse per marker.
      if (wb_hit) begin
        reg_shadow <= trace_wbdata;    // visible to markers from the next cycle on.
      end
    end
  end

  // the event captures the shadow as it was before this cycle's writeback.
  always_ff @(posedge clk) begin
    if (is_marker) begin
      evt_id    <= trace_insn[15:0];
      evt_value <= reg_shadow;
      evt_ts    <= ts_count;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the testbench and RTL with Verilator, runs it and checks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_stm_top -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_stm_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
echo "pass line not found in the simulation output"
exit 1

/* tb.f */
design/stm_pkg.sv
design/stm_trace_capture.sv
design/stm_event_fifo.sv
design/stm_packetizer.sv
design/stm_top.sv
verification/tb_stm_top.sv

/* verification/tb_stm_top.sv */
`timescale 1ns/1ps
`default_nettype none
// ############################################################
// random CPU trace with a fixed seed, checked against a packet model.
// the overflow count check assumes the link is stalled before the burst starts.
// ############################################################

module tb_stm_top;
  import stm_pkg::*;

  localparam int          fifo_depth = 8;
  localparam logic [15:0] host_addr  = 16'h0a51;
  localparam logic [15:0] module_id  = 16'h0c3e;
  localparam int          burst_len  = 20;  // dense markers, well past fifo_depth + 1.

  logic        clk = 1'b0;
  logic        arst_n;
  logic [15:0] id;
  logic        trace_valid;
  logic [31:0] trace_insn;
  logic        trace_wben;
  logic [4:0]  trace_wbreg;
  logic [31:0] trace_wbdata;
  logic        debug_out_ready;
  logic        debug_out_valid;
  logic [15:0] debug_out_data;
  logic        debug_out_last;

  int          seed = 15036;
  int          cyc;                 // model timestamp, zero in the first cycle out of reset.
  int          last_marker = -100;  // cycle of the last counted marker.
  logic [31:0] shadow;              // model copy of register 3.
  logic [79:0] exp_q[$];            // {id, value, ts} per marker, oldest first.
  logic [15:0] pkt_q[$];            // flits of the packet being received.
  int          markers_sent;
  int          traces_rx;
  int          lost_sum;
  int          ovf_pkts;
  int          flits_seen;
  int          skipped_total;       // expected events that never arrived.
  int          mismatch_count;
  int          failure_count;
  bit          timed_out;
  logic        stall_prev;
  logic [15:0] data_prev;
  logic        last_prev;

  stm_top #(
    .fifo_depth(fifo_depth),
    .host_addr(host_addr)
  ) uut (
    .clk, .arst_n, .id, .trace_valid, .trace_insn, .trace_wben, .trace_wbreg, .trace_wbdata,
    .debug_out_valid, .debug_out_data, .debug_out_last, .debug_out_ready
  );

  always #4 clk = ~clk;  // 8 ns period.

  task automatic log_mismatch(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    mismatch_count++;
    $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  task automatic flag_error(input string msg);
    failure_count++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  // drives one CPU cycle and updates the model, then moves to 1 ns after the next edge.
  task automatic step_cycle(input logic valid, input logic [31:0] insn, input logic wben,
                            input logic [4:0] wbreg, input logic [31:0] wbdata,
                            input logic ready);
    trace_valid     = valid;
    trace_insn      = insn;
    trace_wben      = wben;
    trace_wbreg     = wbreg;
    trace_wbdata    = wbdata;
    debug_out_ready = ready;
    if (valid && (insn[31:16] == 16'h1500) && (insn[15:0] != 16'h0000)) begin
      exp_q.push_back({insn[15:0], shadow, 32'(cyc)});  // value from before this writeback.
      markers_sent++;
      last_marker = cyc;
    end
    if (wben && (wbreg == 5'd3)) shadow = wbdata;
    @(posedge clk);
    #1;
    cyc++;
  endtask

  // one random cycle; markers keep a gap of 20 cycles so the FIFO never fills.
  task automatic random_cycle(input bit allow_marker, input bit random_ready);
    logic [31:0] r;
    logic [31:0] w;
    logic [31:0] v;
    logic [31:0] insn;
    r = $random(seed);
    w = $random(seed);
    v = $random(seed);
    if ((r[4:2] == 3'd0) && allow_marker && (cyc - last_marker >= 20)) begin
      insn = {16'h1500, (w[15:0] == 16'h0000) ? 16'h0001 : w[15:0]};
    end else if (r[4:2] == 3'd1) begin
      insn = 32'h1500_0000;  // zero id, so not a marker.
    end else begin
      insn = (w[31:16] == 16'h1500) ? ~w : w;  // stray insns never carry the opcode.
    end
    step_cycle(r[0] | r[1], insn, r[5], r[6] ? 5'd3 : r[11:7], v,
               random_ready ? (r[13:12] != 2'b00) : 1'b1);
  endtask

  // idles with ready high until every marker is accounted for and the link is quiet.
  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (!timed_out && !((traces_rx + lost_sum == markers_sent) && !debug_out_valid)) begin
      step_cycle(1'b0, 32'h0, 1'b0, 5'd0, 32'h0, 1'b1);
      n++;
      if (n > limit) begin
        timed_out = 1'b1;
        flag_error("timeout while waiting for the pending packets to drain");
      end
    end
  endtask

  task automatic check_packet();
    logic [79:0] head;
    logic [31:0] rx_ts;
    logic [31:0] rx_val;
    int          skipped;
    bit          found;
    skipped = 0;
    found   = 1'b0;
    assert (pkt_q[0] == host_addr)
      else log_mismatch("dest flit", 32'(host_addr), 32'(pkt_q[0]));
    if (pkt_q.size() > 1) begin
      assert (pkt_q[1] == module_id)
        else log_mismatch("src flit", 32'(module_id), 32'(pkt_q[1]));
    end
    if ((pkt_q.size() > 2) && (pkt_q[2] == evt_overflow)) begin
      assert (pkt_q.size() == 4) else flag_error("overflow packet is not 4 flits long");
      if (pkt_q.size() == 4) begin
        assert (pkt_q[3] != 16'h0000) else flag_error("overflow packet reports no lost events");
        lost_sum += int'(pkt_q[3]);
        ovf_pkts++;
      end
    end else if ((pkt_q.size() > 2) && (pkt_q[2] == evt_trace)) begin
      assert (pkt_q.size() == 8) else flag_error("trace packet is not 8 flits long");
      if (pkt_q.size() == 8) begin
        rx_ts  = {pkt_q[4], pkt_q[3]};
        rx_val = {pkt_q[7], pkt_q[6]};
        while (!found && (exp_q.size() > 0)) begin  // timestamps are unique per marker.
          head = exp_q.pop_front();
          if (head[31:0] == rx_ts) found = 1'b1;
          else skipped++;
        end
        assert (found) else flag_error("trace packet matches no pending marker");
        if (found) begin
          assert (pkt_q[5] == head[79:64])
            else log_mismatch("trace id", 32'(head[79:64]), 32'(pkt_q[5]));
          assert (rx_val == head[63:32])
            else log_mismatch("trace value", head[63:32], rx_val);
          traces_rx++;
          skipped_total += skipped;
          // drops must be reported before any event that was queued after them.
          assert (lost_sum >= skipped_total)
            else flag_error("event after a gap came before its overflow packet");
        end
      end
    end else begin
      flag_error("packet is too short or has an unknown type");
    end
  endtask

  // the link only changes right after a rising edge, so the falling edge sees it settled.
  always @(negedge clk) begin
    if (!arst_n) begin
      assert (!debug_out_valid) else flag_error("debug_out_valid is high during reset");
      stall_prev = 1'b0;
    end else begin
      if (stall_prev) begin
        assert (debug_out_valid) else flag_error("debug_out_valid dropped during a stall");
        assert (debug_out_data == data_prev)
          else log_mismatch("debug_out_data", 32'(data_prev), 32'(debug_out_data));
        assert (debug_out_last == last_prev)
          else log_mismatch("debug_out_last", 32'(last_prev), 32'(debug_out_last));
      end
      if (debug_out_valid && debug_out_ready) begin
        flits_seen++;
        pkt_q.push_back(debug_out_data);
        if (debug_out_last) begin
          check_packet();
          pkt_q.delete();
        end
      end
      stall_prev = debug_out_valid && !debug_out_ready;
      data_prev  = debug_out_data;
      last_prev  = debug_out_last;
    end
  end

  initial begin
    int          i;
    logic [31:0] r;
    logic [31:0] v;
    arst_n          = 1'b0;
    id              = module_id;
    trace_valid     = 1'b0;
    trace_insn      = '0;
    trace_wben      = 1'b0;
    trace_wbreg     = '0;
    trace_wbdata    = '0;
    debug_out_ready = 1'b1;
    shadow          = '0;
    repeat (16) @(posedge clk);
    #1 arst_n = 1'b1;
    cyc = 0;
    repeat (40) random_cycle(1'b0, 1'b0);  // no markers, so the link stays quiet.
    assert (flits_seen == 0) else flag_error("a flit appeared before the first marker");
    repeat (1500) random_cycle(1'b1, 1'b1);
    wait_drain(2000);
    assert (lost_sum == 0) else log_mismatch("lost count with sparse markers", 32'd0, 32'(lost_sum));
    // back to back markers against a stalled link.
    for (i = 0; i < burst_len; i++) begin
      r = $random(seed);
      v = $random(seed);
      step_cycle(1'b1, {16'h1500, 16'h0100 + i[15:0]}, r[0], r[1] ? 5'd3 : r[6:2], v, 1'b0);
    end
    repeat (10) step_cycle(1'b0, 32'h0, 1'b0, 5'd0, 32'h0, 1'b0);
    // ready returns and one more marker is queued behind the buffered burst events.
    // it must not reach the host before the overflow packet for the drops ahead of it.
    repeat (30) step_cycle(1'b0, 32'h0, 1'b0, 5'd0, 32'h0, 1'b1);
    step_cycle(1'b1, 32'h1500_0200, 1'b0, 5'd0, 32'h0, 1'b1);
    wait_drain(1000);
    assert (lost_sum == burst_len - fifo_depth - 1)
      else log_mismatch("lost count after burst", 32'(burst_len - fifo_depth - 1), 32'(lost_sum));
    assert (ovf_pkts > 0) else flag_error("no overflow packet after the dense burst");
    repeat (300) random_cycle(1'b1, 1'b1);  // the first marker here follows the gap.
    wait_drain(2000);
    assert (traces_rx + lost_sum == markers_sent)
      else log_mismatch("markers accounted", 32'(markers_sent), 32'(traces_rx + lost_sum));
    assert (skipped_total == lost_sum)
      else log_mismatch("missing trace packets", 32'(lost_sum), 32'(skipped_total));
    $display("checks done with %0d mismatches and %0d other errors",
             mismatch_count, failure_count);
    if ((mismatch_count == 0) && (failure_count == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
